// File: source/routerPkg.sv
package routerPkg;

  // ========================================
  // Ports and flits
  // ========================================

  localparam int NumPorts = 5;         // L, N, E, W, S

  typedef logic [2:0] portIdx_t;       // 0 = Local ... 4 = South

  localparam logic [2:0] FlitHead = 3'd1;

  typedef struct packed {
    logic [2:0]  flitId;               // 1 marks a head flit
    logic [11:0] length;               // Requested hold in flits
    logic [31:0] data;
  } flit_t;

  // ========================================
  // Grant state
  // ========================================

  // One-hot, bit 0 idle, bits 1..5 the granted port
  typedef logic [5:0] grant_t;

  localparam grant_t GrantIdle = 6'b000001;

  // ========================================
  // Wishbone register map
  // ========================================

  localparam logic [3:0] AdrEnable  = 4'd0;  // Port enable mask
  localparam logic [3:0] AdrHoldCap = 4'd1;  // Upper bound on hold
  localparam logic [3:0] AdrStatus  = 4'd2;  // Current grant, read only

endpackage

// File: source/holdTimer.sv
`timescale 1ns/1ps

module holdTimer #(
  parameter int LenWidth = 12
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                headAccept,
  input  logic [LenWidth-1:0] length,
  input  logic [LenWidth-1:0] holdCap,
  input  logic                granted,
  input  logic                accept,
  output logic                expired
);

  logic [LenWidth-1:0] limit;
  logic [LenWidth-1:0] count;
  logic [LenWidth-1:0] limitNext;
  logic [LenWidth-1:0] countNext;

  always_comb
  begin
    limitNext = limit;
    if (headAccept)
    begin
      limitNext = (length < holdCap) ? length : holdCap;  // Capped length
    end
  end

  assign countNext = granted ? count + LenWidth'(accept) : '0;

  // Compared after this cycle's flit, so the Nth accepted flit
  // already turns the grant over on the same edge
  assign expired = (countNext >= limitNext);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      limit <= limitNext;
      count <= countNext;
    end
  end

endmodule

// File: source/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter #(
  parameter int LenWidth = 12
) (
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::flit_t               inFlit [routerPkg::NumPorts],
  input  logic [routerPkg::NumPorts-1:0] inValid,
  output logic [routerPkg::NumPorts-1:0] inReady,
  output routerPkg::flit_t               outFlit,
  output logic                           outValid,
  input  logic                           outReady,
  input  logic [routerPkg::NumPorts-1:0] portEnable,
  input  logic [LenWidth-1:0]            holdCap,
  output routerPkg::grant_t              grantState
);

  routerPkg::grant_t              stateNext;
  routerPkg::portIdx_t            curIdx;
  logic [routerPkg::NumPorts-1:0] granted;
  logic [routerPkg::NumPorts-1:0] request;
  logic [routerPkg::NumPorts-1:0] accept;
  logic [routerPkg::NumPorts-1:0] headAccept;
  logic [routerPkg::NumPorts-1:0] expired;

  // ========================================
  // Handshake
  // ========================================

  assign granted = grantState[routerPkg::NumPorts:1];
  assign request = inValid & portEnable;
  assign inReady = granted & {routerPkg::NumPorts{outReady}};
  assign accept  = inValid & inReady;

  genvar p;
  generate
    for (p = 0; p < routerPkg::NumPorts; p++)
    begin : genTimer
      assign headAccept[p] = accept[p] && (inFlit[p].flitId == routerPkg::FlitHead);

      holdTimer #(
        .LenWidth(LenWidth)
      ) i_holdTimer (
        .clk       (clk),
        .rst       (rst),
        .headAccept(headAccept[p]),
        .length    (LenWidth'(inFlit[p].length)),
        .holdCap   (holdCap),
        .granted   (granted[p]),
        .accept    (accept[p]),
        .expired   (expired[p])
      );
    end
  endgenerate

  // ========================================
  // Round-robin state
  // ========================================

  always_comb
  begin
    curIdx = '0;
    for (int k = 0; k < routerPkg::NumPorts; k++)
    begin
      if (granted[k])
      begin
        curIdx = routerPkg::portIdx_t'(k);
      end
    end
  end

  always_comb
  begin
    int idx;
    idx       = 0;
    stateNext = routerPkg::GrantIdle;
    if (grantState[0])
    begin
      // Fixed priority from idle, Local first
      for (int k = routerPkg::NumPorts - 1; k >= 0; k--)
      begin
        if (request[k])
        begin
          stateNext = routerPkg::grant_t'(1 << (k + 1));
        end
      end
    end
    else if (request[curIdx] && !expired[curIdx])
    begin
      stateNext = grantState;                                // Keep holding
    end
    else
    begin
      for (int k = routerPkg::NumPorts - 1; k >= 1; k--)
      begin
        idx = (int'(curIdx) + k) % routerPkg::NumPorts;      // Next in ring wins
        if (request[idx])
        begin
          stateNext = routerPkg::grant_t'(1 << (idx + 1));
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantState <= routerPkg::GrantIdle;
    end
    else
    begin
      grantState <= stateNext;
    end
  end

  // ========================================
  // Flit multiplexer
  // ========================================

  assign outFlit  = inFlit[curIdx];
  assign outValid = |(inValid & granted);

  assert property (@(posedge clk) disable iff (rst) $onehot(grantState))
    else $error("grantState not one-hot: %b", grantState);

  assert property (@(posedge clk) disable iff (rst) grantState[0] |-> !outValid)
    else $error("outValid high while the arbiter is idle");

endmodule

// File: source/arbConfig.sv
`timescale 1ns/1ps

module arbConfig #(
  parameter int LenWidth = 12
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           wbCyc,
  input  logic                           wbStb,
  input  logic                           wbWe,
  input  logic [3:0]                     wbAdr,
  input  logic [31:0]                    wbDatW,
  output logic [31:0]                    wbDatR,
  output logic                           wbAck,
  input  routerPkg::grant_t              grantState,
  output logic [routerPkg::NumPorts-1:0] portEnable,
  output logic [LenWidth-1:0]            holdCap
);

  logic request;
  logic writeStrobe;

  // One transfer per ack, the cycle after ack is always idle
  assign request     = wbCyc && wbStb && !wbAck;
  assign writeStrobe = request && wbWe;

  // ========================================
  // Registers
  // ========================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wbAck      <= 1'b0;
      portEnable <= '1;                 // All ports on
      holdCap    <= '1;                 // No cap below the flit length
    end
    else
    begin
      wbAck <= request;
      if (writeStrobe)
      begin
        case (wbAdr)
          routerPkg::AdrEnable:
          begin
            portEnable <= wbDatW[routerPkg::NumPorts-1:0];
          end
          routerPkg::AdrHoldCap:
          begin
            holdCap <= LenWidth'(wbDatW);
          end
          default:
          begin
            portEnable <= portEnable;   // Status and holes ignore writes
          end
        endcase
      end
    end
  end

  // ========================================
  // Read decode
  // ========================================

  always_comb
  begin
    case (wbAdr)
      routerPkg::AdrEnable:  wbDatR = 32'(portEnable);
      routerPkg::AdrHoldCap: wbDatR = 32'(holdCap);
      routerPkg::AdrStatus:  wbDatR = 32'(grantState);
      default:               wbDatR = '0;
    endcase
  end

  assert property (@(posedge clk) disable iff (rst) wbAck |-> $past(wbCyc && wbStb))
    else $error("wbAck without cyc and stb on the previous cycle");

endmodule

// File: source/routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort #(
  parameter int LenWidth = 12
) (
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::flit_t               inFlit [routerPkg::NumPorts],
  input  logic [routerPkg::NumPorts-1:0] inValid,
  output logic [routerPkg::NumPorts-1:0] inReady,
  output routerPkg::flit_t               outFlit,
  output logic                           outValid,
  input  logic                           outReady,
  input  logic                           wbCyc,
  input  logic                           wbStb,
  input  logic                           wbWe,
  input  logic [3:0]                     wbAdr,
  input  logic [31:0]                    wbDatW,
  output logic [31:0]                    wbDatR,
  output logic                           wbAck
);

  logic [routerPkg::NumPorts-1:0] portEnable;
  logic [LenWidth-1:0]            holdCap;
  routerPkg::grant_t              grantState;   // Back to config for status

  outputArbiter #(
    .LenWidth(LenWidth)
  ) i_outputArbiter (
    .clk       (clk),
    .rst       (rst),
    .inFlit    (inFlit),
    .inValid   (inValid),
    .inReady   (inReady),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outReady  (outReady),
    .portEnable(portEnable),
    .holdCap   (holdCap),
    .grantState(grantState)
  );

  arbConfig #(
    .LenWidth(LenWidth)
  ) i_arbConfig (
    .clk       (clk),
    .rst       (rst),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatW    (wbDatW),
    .wbDatR    (wbDatR),
    .wbAck     (wbAck),
    .grantState(grantState),
    .portEnable(portEnable),
    .holdCap   (holdCap)
  );

endmodule

// File: verification/tbRouterOutputPort.sv
`timescale 1ns/1ps

module tbRouterOutputPort;

  localparam int LenWidth   = 12;
  localparam int Period     = 100;
  localparam int DrainLimit = 150;                        // Cycles one drain may take
  localparam int BusLimit   = 20;                         // Cycles one bus access may wait
  // Six drains, seven bus accesses and the fixed waits, each at its limit
  localparam int TestCycles = 6 * DrainLimit + 7 * (BusLimit + 1) + 40;

  logic                           clk;
  logic                           rst;
  routerPkg::flit_t               inFlit [routerPkg::NumPorts];
  logic [routerPkg::NumPorts-1:0] inValid;
  logic [routerPkg::NumPorts-1:0] inReady;
  routerPkg::flit_t               outFlit;
  logic                           outValid;
  logic                           outReady;
  logic                           wbCyc;
  logic                           wbStb;
  logic                           wbWe;
  logic [3:0]                     wbAdr;
  logic [31:0]                    wbDatW;
  logic [31:0]                    wbDatR;
  logic                           wbAck;

  routerPkg::flit_t               flitQ [routerPkg::NumPorts][$];
  routerPkg::grant_t              modelState;
  logic [LenWidth-1:0]            modelLimit [routerPkg::NumPorts];
  logic [LenWidth-1:0]            modelCount [routerPkg::NumPorts];
  logic [routerPkg::NumPorts-1:0] modelEnable;
  logic [LenWidth-1:0]            modelCap;
  routerPkg::flit_t               expFlit;
  logic [31:0]                    expRead;
  logic [31:0]                    rngState;
  int                             errorCount;
  int                             testErrors;
  int                             testsPassed;
  int                             testsFailed;

  routerOutputPort #(
    .LenWidth(LenWidth)
  ) i_routerOutputPort (
    .clk     (clk),
    .rst     (rst),
    .inFlit  (inFlit),
    .inValid (inValid),
    .inReady (inReady),
    .outFlit (outFlit),
    .outValid(outValid),
    .outReady(outReady),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbWe    (wbWe),
    .wbAdr   (wbAdr),
    .wbDatW  (wbDatW),
    .wbDatR  (wbDatR),
    .wbAck   (wbAck)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(Period / 2) clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic void reportValue(input string name, input logic [63:0] exp,
                                      input logic [63:0] act);
    errorCount++;
    $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
  endfunction

  // ========================================
  // Reference model of the grant
  // ========================================

  always @(posedge clk)
  begin
    logic [routerPkg::NumPorts-1:0] req;
    logic [routerPkg::NumPorts-1:0] acc;
    logic [routerPkg::NumPorts-1:0] done;
    logic [LenWidth-1:0]            lim;
    logic [LenWidth-1:0]            cnt;
    int                             cur;
    int                             q;
    if (rst)
    begin
      modelState <= routerPkg::GrantIdle;
      for (int p = 0; p < routerPkg::NumPorts; p++)
      begin
        modelLimit[p] <= '0;
        modelCount[p] <= '0;
      end
    end
    else
    begin
      req = inValid & modelEnable;
      acc = inValid & modelState[5:1] & {5{outReady}};
      cur = 0;
      for (int p = 0; p < routerPkg::NumPorts; p++)
      begin
        lim = modelLimit[p];
        if (acc[p] && inFlit[p].flitId == 3'd1)
          lim = (inFlit[p].length < modelCap) ? inFlit[p].length : modelCap;
        cnt = modelState[p + 1] ? modelCount[p] + acc[p] : '0;
        done[p] = (cnt >= lim);                           // Limit reached with this flit
        modelLimit[p] <= lim;
        modelCount[p] <= cnt;
        if (modelState[p + 1])
          cur = p;
      end
      if (modelState[0])
      begin
        modelState <= routerPkg::GrantIdle;
        for (int p = routerPkg::NumPorts - 1; p >= 0; p--)
          if (req[p])
            modelState <= routerPkg::grant_t'(1 << (p + 1));
      end
      else if (!(req[cur] && !done[cur]))
      begin
        modelState <= routerPkg::GrantIdle;
        for (int k = 4; k >= 1; k--)
        begin
          q = (cur + k) % routerPkg::NumPorts;
          if (req[q])
            modelState <= routerPkg::grant_t'(1 << (q + 1));
        end
      end
    end
  end

  // ========================================
  // Checks against the model
  // ========================================

  always_comb
  begin
    expFlit = '0;
    for (int p = 0; p < routerPkg::NumPorts; p++)
      if (modelState[p + 1])
        expFlit = inFlit[p];
  end

  always_comb
  begin
    case (wbAdr)
      routerPkg::AdrEnable:  expRead = 32'(modelEnable);
      routerPkg::AdrHoldCap: expRead = 32'(modelCap);
      routerPkg::AdrStatus:  expRead = 32'(modelState);
      default:               expRead = '0;
    endcase
  end

  assert property (@(posedge clk) disable iff (rst)
    outValid == |(inValid & modelState[5:1]))
    else reportValue("outValid", $sampled(|(inValid & modelState[5:1])), $sampled(outValid));

  assert property (@(posedge clk) disable iff (rst)
    inReady == (modelState[5:1] & {5{outReady}}))
    else reportValue("inReady", $sampled(modelState[5:1] & {5{outReady}}), $sampled(inReady));

  assert property (@(posedge clk) disable iff (rst)
    !modelState[0] |-> outFlit == expFlit)
    else reportValue("outFlit", $sampled(expFlit), $sampled(outFlit));

  assert property (@(posedge clk) disable iff (rst)
    (wbCyc && wbStb && !wbWe) |-> wbDatR == expRead)
    else reportValue("wbDatR", $sampled(expRead), $sampled(wbDatR));

  // ========================================
  // Port drivers and bus tasks
  // ========================================

  always
  begin
    logic [routerPkg::NumPorts-1:0] taken;
    logic [routerPkg::NumPorts-1:0] nextValid;
    routerPkg::flit_t               nextFlit [routerPkg::NumPorts];
    @(posedge clk);
    taken = inValid & inReady;
    for (int p = 0; p < routerPkg::NumPorts; p++)
    begin
      if (taken[p] && flitQ[p].size() > 0)
        void'(flitQ[p].pop_front());
      nextValid[p] = (flitQ[p].size() > 0);
      nextFlit[p]  = nextValid[p] ? flitQ[p][0] : '0;
    end
    #10;
    inValid = nextValid;
    inFlit  = nextFlit;
  end

  task automatic pushPacket(input int port, input int len);
    routerPkg::flit_t f;
    for (int i = 0; i < len; i++)
    begin
      rngState = xorshift(rngState);
      f.flitId = (i == 0) ? 3'd1 : 3'd2;
      f.length = (i == 0) ? 12'(len) : 12'd0;
      f.data   = {4'(port), rngState[27:0]};               // Source port in top bits
      flitQ[port].push_back(f);
    end
  endtask

  task automatic busAccess(input logic we, input logic [3:0] adr, input logic [31:0] dat);
    int waited;
    waited = 0;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatW = dat;
    do
    begin
      @(posedge clk);
      #10;
      waited++;
    end
    while (!wbAck && waited < BusLimit);
    if (!wbAck)
    begin
      errorCount++;
      $display("Bus transfer at address %0d never got an ack", adr);
    end
    else
    begin
      if (waited != 1)
      begin
        errorCount++;
        $display("Ack at address %0d came %0d cycles after the request instead of one",
                 adr, waited);
      end
      if (we && adr == routerPkg::AdrEnable)
        modelEnable = dat[4:0];
      else if (we && adr == routerPkg::AdrHoldCap)
        modelCap = dat[LenWidth-1:0];
      @(posedge clk);                                      // Strobe still high
      #10;
      if (wbAck)
        reportValue("wbAck", 64'd0, 64'(wbAck));
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic waitDrain();
    int waited;
    waited = 0;
    while (flitQ[0].size() + flitQ[1].size() + flitQ[2].size()
           + flitQ[3].size() + flitQ[4].size() > 0 && waited < DrainLimit)
    begin
      @(posedge clk);
      #10;
      waited++;
    end
    if (waited >= DrainLimit)
    begin
      errorCount++;
      $display("Queued flits were not all forwarded within %0d cycles", DrainLimit);
    end
  endtask

  task automatic finishTest(input string name);
    if (errorCount == testErrors)
      testsPassed++;
    else
      testsFailed++;
    $display("%s: %0d errors", name, errorCount - testErrors);
    testErrors = errorCount;
  endtask

  // ========================================
  // Tests
  // ========================================

  initial
  begin
    #(TestCycles * Period + 5000);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  initial
  begin
    rst         = 1'b1;
    inValid     = '0;
    outReady    = 1'b1;
    wbCyc       = 1'b0;
    wbStb       = 1'b0;
    wbWe        = 1'b0;
    wbAdr       = '0;
    wbDatW      = '0;
    modelEnable = 5'h1f;
    modelCap    = '1;
    rngState    = 32'hc27f;
    errorCount  = 0;
    testErrors  = 0;
    testsPassed = 0;
    testsFailed = 0;
    for (int p = 0; p < routerPkg::NumPorts; p++)
      inFlit[p] = '0;
    repeat (2) @(posedge clk);
    #10 rst = 1'b0;

    busAccess(1'b0, routerPkg::AdrStatus, '0);
    busAccess(1'b0, routerPkg::AdrEnable, '0);
    busAccess(1'b0, routerPkg::AdrHoldCap, '0);
    finishTest("reset values");

    pushPacket(1, 6);                                      // North alone
    waitDrain();
    finishTest("single port");

    for (int r = 0; r < 2; r++)
      for (int p = 0; p < routerPkg::NumPorts; p++)
        pushPacket(p, 1);
    waitDrain();
    finishTest("round robin");

    pushPacket(2, 5);
    pushPacket(3, 2);
    waitDrain();
    busAccess(1'b1, routerPkg::AdrHoldCap, 32'd3);
    pushPacket(2, 6);
    pushPacket(0, 2);
    waitDrain();
    finishTest("hold length and cap");

    busAccess(1'b1, routerPkg::AdrEnable, 32'h1b);         // East off
    pushPacket(2, 3);
    pushPacket(1, 2);
    repeat (20) @(posedge clk);
    #10;
    busAccess(1'b0, routerPkg::AdrStatus, '0);
    busAccess(1'b1, routerPkg::AdrEnable, 32'h1f);
    waitDrain();
    finishTest("port enable");

    pushPacket(4, 5);
    pushPacket(0, 2);
    repeat (3) @(posedge clk);                             // Local head already taken
    #10 outReady = 1'b0;
    repeat (6) @(posedge clk);
    #10 outReady = 1'b1;
    waitDrain();
    finishTest("back-pressure");

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             testsPassed, testsFailed, errorCount);
    if (errorCount == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: tb.f
source/routerPkg.sv
source/holdTimer.sv
source/outputArbiter.sv
source/arbConfig.sv
source/routerOutputPort.sv
verification/tbRouterOutputPort.sv
